// File: common/icache_pkg.sv
package icache_pkg;

    // One instruction, or one word returned by memory
    typedef logic [31:0] instr_word_t;

    // Request from the fetch unit
    typedef struct packed {
        logic [31:0] address;
        logic        fetch;
        logic        invalidate;
    } fetch_req_t;

    // Answer to the fetch unit
    typedef struct packed {
        instr_word_t instruction;
        logic        valid;
        logic        stall;
    } fetch_rsp_t;

    // Block refill request towards memory
    typedef struct packed {
        // Always aligned to the start of a block
        logic [31:0] address;
        // Single cycle pulse
        logic        request;
    } load_req_t;

    // Refill words of a block come back one at a time in ascending order
    typedef struct packed {
        instr_word_t word;
        logic        valid;
    } load_rsp_t;

endpackage : icache_pkg

// File: icache/icache_tag_array.sv
`timescale 1ns/1ns

module icache_tag_array #(
    parameter int CACHE_SIZE = 16384,
    parameter int BLOCK_SIZE = 32
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        read_i,
    input  logic [31:0] read_address_i,
    input  logic        write_i,
    input  logic [31:0] write_address_i,
    input  logic        invalidate_i,
    output logic        hit_o
);

    localparam int OFFSET = $clog2(BLOCK_SIZE / 4);
    localparam int INDEX  = $clog2(CACHE_SIZE / BLOCK_SIZE);
    localparam int TAG    = 32 - (2 + OFFSET + INDEX);
    localparam int DEPTH  = CACHE_SIZE / BLOCK_SIZE;

    logic [TAG-1:0]   tag_mem [DEPTH];
    logic [DEPTH-1:0] valid_q;

    logic [INDEX-1:0] read_index;
    logic [INDEX-1:0] write_index;
    logic [TAG-1:0]   read_tag;
    logic [TAG-1:0]   write_tag;

    // Registered lookup result
    logic [TAG-1:0]   stored_tag_q;
    logic [TAG-1:0]   lookup_tag_q;
    logic             valid_rd_q;

    assign read_index  = read_address_i[OFFSET + 2 +: INDEX];
    assign read_tag    = read_address_i[31 -: TAG];
    assign write_index = write_address_i[OFFSET + 2 +: INDEX];
    assign write_tag   = write_address_i[31 -: TAG];

    // Tags live in RAM, valid bits in flops so they can be cleared at once
    always_ff @(posedge clk_i) begin
        if (write_i) begin
            tag_mem[write_index] <= write_tag;
        end
        if (read_i) begin
            stored_tag_q <= tag_mem[read_index];
            lookup_tag_q <= read_tag;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || invalidate_i) begin
            valid_q <= '0;
        end else if (write_i) begin
            valid_q[write_index] <= 1'b1;
        end
    end

    // Invalidate also kills a lookup that is in flight
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || invalidate_i) begin
            valid_rd_q <= 1'b0;
        end else if (read_i) begin
            valid_rd_q <= valid_q[read_index];
        end
    end

    assign hit_o = valid_rd_q & (stored_tag_q == lookup_tag_q);

endmodule : icache_tag_array

// File: icache/icache_word_bank.sv
`timescale 1ns/1ns

module icache_word_bank #(
    parameter int DEPTH = 512
) (
    input  logic                       clk_i,
    input  logic                       read_i,
    input  logic [$clog2(DEPTH)-1:0]   read_index_i,
    input  logic                       write_i,
    input  logic [$clog2(DEPTH)-1:0]   write_index_i,
    input  icache_pkg::instr_word_t    word_i,
    output icache_pkg::instr_word_t    word_o
);

    import icache_pkg::*;

    // Same word position of every block
    instr_word_t mem [DEPTH];

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            mem[write_index_i] <= word_i;
        end
    end

    // Output only changes on a read, so a bundle stays stable between reads
    always_ff @(posedge clk_i) begin
        if (read_i) begin
            word_o <= mem[read_index_i];
        end
    end

endmodule : icache_word_bank

// File: hw/fetch_controller.sv
`timescale 1ns/1ns

module fetch_controller #(
    parameter int BLOCK_SIZE = 32
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      fetch_i,
    input  logic                      invalidate_i,
    input  logic [31:0]               address_i,
    input  logic                      hit_i,
    input  icache_pkg::load_rsp_t     load_rsp_i,
    output logic                      read_o,
    output logic [31:0]               read_address_o,
    output logic                      tag_write_o,
    output logic [31:0]               write_address_o,
    output logic [BLOCK_SIZE/4-1:0]   bank_write_o,
    output icache_pkg::instr_word_t   bank_word_o,
    output logic                      bundle_valid_o,
    output logic                      stall_o,
    output icache_pkg::load_req_t     load_req_o
);

    localparam int BLOCK_WORDS = BLOCK_SIZE / 4;
    localparam int OFFSET      = $clog2(BLOCK_WORDS);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_LOOKUP = 2'd1;
    localparam logic [1:0] ST_REFILL = 2'd2;
    localparam logic [1:0] ST_REREAD = 2'd3;

    logic [1:0]        state_q;
    logic [1:0]        state_d;

    // Address of the fetch being served
    logic [31:0]       addr_q;

    // Position of the next refill word inside the block
    logic [OFFSET-1:0] word_cnt_q;

    logic              miss_q;
    logic              abort_q;
    logic              load_pulse_q;
    logic              word_arrived;
    logic              last_word;

    assign word_arrived = (state_q == ST_REFILL) & load_rsp_i.valid;
    assign last_word    = word_arrived & (word_cnt_q == OFFSET'(BLOCK_WORDS - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (fetch_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                state_d = hit_i ? ST_IDLE : ST_REFILL;
            end
            ST_REFILL: begin
                if (last_word) begin
                    state_d = ST_REREAD;
                end
            end
            ST_REREAD: begin
                state_d = ST_LOOKUP;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= ST_IDLE;
            miss_q       <= 1'b0;
            abort_q      <= 1'b0;
            load_pulse_q <= 1'b0;
            word_cnt_q   <= '0;
        end else begin
            state_q      <= state_d;
            load_pulse_q <= (state_q == ST_LOOKUP) & ~hit_i;

            // Miss stays open until the reread finally hits
            if (state_q == ST_LOOKUP) begin
                miss_q <= ~hit_i;
            end

            // A new refill starts clean, an invalidate in the middle spoils it
            if (state_q == ST_LOOKUP) begin
                abort_q <= 1'b0;
            end else if (invalidate_i && (state_q == ST_REFILL)) begin
                abort_q <= 1'b1;
            end

            if (state_q == ST_LOOKUP) begin
                word_cnt_q <= '0;
            end else if (word_arrived) begin
                word_cnt_q <= word_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == ST_IDLE) && fetch_i) begin
            addr_q <= address_i;
        end
    end

    // First lookup uses the incoming PC, the reread the latched one
    assign read_o         = ((state_q == ST_IDLE) & fetch_i) | (state_q == ST_REREAD);
    assign read_address_o = (state_q == ST_IDLE) ? address_i : addr_q;

    assign write_address_o = addr_q;
    assign bank_word_o     = load_rsp_i.word;
    assign bank_write_o    = word_arrived ? (BLOCK_WORDS'(1) << word_cnt_q) : '0;

    // Tag goes in with the last word unless the block was invalidated meanwhile
    assign tag_write_o = last_word & ~abort_q & ~invalidate_i;

    assign bundle_valid_o = (state_q == ST_LOOKUP) & hit_i;
    assign stall_o        = miss_q & ~bundle_valid_o;

    assign load_req_o.address = {addr_q[31:OFFSET + 2], {(OFFSET + 2){1'b0}}};
    assign load_req_o.request = load_pulse_q;

endmodule : fetch_controller

// File: hw/instruction_sequencer.sv
`timescale 1ns/1ns

module instruction_sequencer #(
    parameter int BLOCK_SIZE = 32
) (
    input  logic                                       clk_i,
    input  logic                                       rst_n_i,
    input  logic                                       fetch_i,
    input  logic                                       invalidate_i,
    input  logic [31:0]                                address_i,
    input  icache_pkg::instr_word_t [BLOCK_SIZE/4-1:0] bundle_i,
    input  logic                                       bundle_valid_i,
    output logic                                       bundle_request_o,
    output icache_pkg::instr_word_t                    fetch_rsp_instruction_o,
    output logic                                       fetch_rsp_valid_o
);

    import icache_pkg::*;

    localparam int BLOCK_WORDS = BLOCK_SIZE / 4;
    localparam int OFFSET      = $clog2(BLOCK_WORDS);

    logic [31:0]                   prev_pc_q;

    // Words that follow the last one handed out, head at index 0
    instr_word_t [BLOCK_WORDS-2:0] shift_q;
    logic [OFFSET-1:0]             count_q;

    logic [OFFSET-1:0]             offset;
    logic [BLOCK_WORDS*32-1:0]     bundle_tail;
    logic                          sequential;

    // By the time the bundle arrives the PC register holds the fetch address
    assign offset      = prev_pc_q[OFFSET + 1:2];
    assign bundle_tail = bundle_i >> ((32'(offset) + 32'd1) * 32);

    assign bundle_request_o = (count_q == '0) | (address_i != (prev_pc_q + 32'd4))
                            | invalidate_i;
    assign sequential       = fetch_i & ~bundle_request_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prev_pc_q <= '0;
        end else if (fetch_i) begin
            prev_pc_q <= address_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bundle_valid_i) begin
            shift_q <= bundle_tail[(BLOCK_WORDS - 1) * 32 - 1:0];
        end else if (sequential) begin
            shift_q <= shift_q >> 32;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || invalidate_i) begin
            count_q <= '0;
        end else if (bundle_valid_i) begin
            count_q <= OFFSET'(BLOCK_WORDS - 1) - offset;
        end else if (fetch_i) begin
            // A jump drops whatever is left of the old block
            count_q <= bundle_request_o ? '0 : count_q - 1'b1;
        end
    end

    assign fetch_rsp_instruction_o = bundle_valid_i ? bundle_i[offset] : shift_q[0];
    assign fetch_rsp_valid_o       = sequential | bundle_valid_i;

endmodule : instruction_sequencer

// File: hw/instruction_cache_complex.sv
`timescale 1ns/1ns

module instruction_cache_complex #(
    parameter int CACHE_SIZE = 16384,
    parameter int BLOCK_SIZE = 32
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  icache_pkg::fetch_req_t fetch_req_i,
    output icache_pkg::fetch_rsp_t fetch_rsp_o,
    output icache_pkg::load_req_t  load_req_o,
    input  icache_pkg::load_rsp_t  load_rsp_i
);

    import icache_pkg::*;

    localparam int BLOCK_WORDS = BLOCK_SIZE / 4;
    localparam int DEPTH       = CACHE_SIZE / BLOCK_SIZE;
    localparam int OFFSET      = $clog2(BLOCK_WORDS);
    localparam int INDEX       = $clog2(DEPTH);

    logic                          read;
    logic [31:0]                   read_address;
    logic                          tag_write;
    logic [31:0]                   write_address;
    logic                          hit;
    logic [BLOCK_WORDS-1:0]        bank_write;
    instr_word_t                   bank_word;
    instr_word_t [BLOCK_WORDS-1:0] bundle;
    logic                          bundle_valid;
    logic                          bundle_request;
    logic                          stall;
    instr_word_t                   rsp_instruction;
    logic                          rsp_valid;

    icache_tag_array #(
        .CACHE_SIZE (CACHE_SIZE),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_tag_array (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .read_i          (read),
        .read_address_i  (read_address),
        .write_i         (tag_write),
        .write_address_i (write_address),
        .invalidate_i    (fetch_req_i.invalidate),
        .hit_o           (hit)
    );

    // One bank per word position, all read together to form a bundle
    for (genvar i = 0; i < BLOCK_WORDS; i++) begin : gen_bank
        icache_word_bank #(
            .DEPTH (DEPTH)
        ) u_bank (
            .clk_i         (clk_i),
            .read_i        (read),
            .read_index_i  (read_address[OFFSET + 2 +: INDEX]),
            .write_i       (bank_write[i]),
            .write_index_i (write_address[OFFSET + 2 +: INDEX]),
            .word_i        (bank_word),
            .word_o        (bundle[i])
        );
    end

    // Only fetches the sequencer cannot serve reach the cache
    fetch_controller #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_controller (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .fetch_i         (fetch_req_i.fetch & bundle_request),
        .invalidate_i    (fetch_req_i.invalidate),
        .address_i       (fetch_req_i.address),
        .hit_i           (hit),
        .load_rsp_i      (load_rsp_i),
        .read_o          (read),
        .read_address_o  (read_address),
        .tag_write_o     (tag_write),
        .write_address_o (write_address),
        .bank_write_o    (bank_write),
        .bank_word_o     (bank_word),
        .bundle_valid_o  (bundle_valid),
        .stall_o         (stall),
        .load_req_o      (load_req_o)
    );

    instruction_sequencer #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_sequencer (
        .clk_i                   (clk_i),
        .rst_n_i                 (rst_n_i),
        .fetch_i                 (fetch_req_i.fetch),
        .invalidate_i            (fetch_req_i.invalidate),
        .address_i               (fetch_req_i.address),
        .bundle_i                (bundle),
        .bundle_valid_i          (bundle_valid),
        .bundle_request_o        (bundle_request),
        .fetch_rsp_instruction_o (rsp_instruction),
        .fetch_rsp_valid_o       (rsp_valid)
    );

    assign fetch_rsp_o.instruction = rsp_instruction;
    assign fetch_rsp_o.valid       = rsp_valid;
    assign fetch_rsp_o.stall       = stall;

endmodule : instruction_cache_complex

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

// File: verif/tb_memory_model.sv
`timescale 1ns/1ns

module tb_memory_model #(
    parameter int BLOCK_SIZE = 32
) (
    input  logic                  clk_i,
    input  icache_pkg::load_req_t load_req_i,
    output icache_pkg::load_rsp_t load_rsp_o
);

    import icache_pkg::*;

    localparam int BLOCK_WORDS = BLOCK_SIZE / 4;

    // Memory contents are a scrambled and rotated copy of the word address
    function automatic instr_word_t word_at(input logic [31:0] addr);
        logic [31:0] mixed;
        mixed = {addr[31:2], 2'b00} ^ 32'h6b3a_91d5;
        return {mixed[24:0], mixed[31:25]};
    endfunction

    initial begin : responder
        logic [31:0] base;
        int          delay;
        int          gap;
        load_rsp_o = '0;
        forever begin
            @(posedge clk_i);
            if (load_req_i.request) begin
                base  = load_req_i.address;
                delay = $urandom_range(8, 2);
                repeat (delay) @(negedge clk_i);
                // Words go out in ascending order, with idle cycles in between
                for (int i = 0; i < BLOCK_WORDS; i++) begin
                    gap = $urandom_range(2, 0);
                    if (gap > 0) begin
                        load_rsp_o = '0;
                        repeat (gap) @(negedge clk_i);
                    end
                    load_rsp_o.word  = word_at(base + 32'(i * 4));
                    load_rsp_o.valid = 1'b1;
                    @(negedge clk_i);
                end
                load_rsp_o = '0;
            end
        end
    end

endmodule : tb_memory_model

// File: verif/tb_instruction_cache_complex.sv
`timescale 1ns/1ns

module tb_instruction_cache_complex;

    import icache_pkg::*;

    localparam int          CACHE_SIZE     = 16384;
    localparam int          BLOCK_SIZE     = 32;
    localparam int          TIMEOUT        = 200;
    localparam int          RANDOM_FETCHES = 300;
    localparam logic [31:0] WINDOW_BASE    = 32'h0001_0000;

    // Expected way a fetch gets served
    localparam int KIND_SEQ  = 0;
    localparam int KIND_HIT  = 1;
    localparam int KIND_MISS = 2;
    localparam int KIND_ANY  = 3;

    logic       clk;
    logic       rst_n;
    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    load_req_t  load_req;
    load_rsp_t  load_rsp;

    int error_count   = 0;
    int timeout_count = 0;
    int check_count   = 0;
    int load_count    = 0;

    // Fetches still waiting for their instruction
    logic [31:0] pending[$];

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (16)
    ) u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    tb_memory_model #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_memory (
        .clk_i      (clk),
        .load_req_i (load_req),
        .load_rsp_o (load_rsp)
    );

    instruction_cache_complex instruction_cache_complex_i (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .fetch_req_i (fetch_req),
        .fetch_rsp_o (fetch_rsp),
        .load_req_o  (load_req),
        .load_rsp_i  (load_rsp)
    );

    // Expected memory word at a byte address
    function automatic instr_word_t mem_word(input logic [31:0] addr);
        logic [31:0] mixed;
        mixed = {addr[31:2], 2'b00} ^ 32'h6b3a_91d5;
        return {mixed[24:0], mixed[31:25]};
    endfunction

    function automatic logic [31:0] block_base(input logic [31:0] addr);
        return addr & ~32'(BLOCK_SIZE - 1);
    endfunction

    task automatic check_instr(input string name, input instr_word_t got,
                               input instr_word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t ns %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_load(input string name, input load_req_t got, input load_req_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t ns %s got addr %08h req %0b expected addr %08h req %0b",
                     $time, name, got.address, got.request, exp.address, exp.request);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t ns %s got %0b expected %0b", $time, name, got, exp);
        end
    endtask

    task automatic check_int(input string name, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            error_count++;
            $display("ERR %0t ns %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Compares every response and every refill request on the rising edge
    always @(posedge clk) begin : response_checker
        logic [31:0] fetch_addr;
        load_req_t   exp_req;
        if (rst_n) begin
            if (fetch_req.fetch) begin
                pending.push_back(fetch_req.address);
            end
            if (fetch_rsp.valid) begin
                if (pending.size() == 0) begin
                    error_count++;
                    $display("A valid response came at %0t ns with no fetch pending", $time);
                end else begin
                    fetch_addr = pending.pop_front();
                    check_instr("fetch_rsp_o.instruction", fetch_rsp.instruction,
                                mem_word(fetch_addr));
                end
            end
            if (load_req.request) begin
                load_count++;
                if (pending.size() == 0) begin
                    error_count++;
                    $display("A load request came at %0t ns with no fetch pending", $time);
                end else begin
                    exp_req.address = block_base(pending[0]);
                    exp_req.request = 1'b1;
                    check_load("load_req_o", load_req, exp_req);
                end
            end
        end
    end

    // Starts and ends just after a falling edge
    task automatic run_fetch(input logic [31:0] addr, output int latency, output int loads,
                             output logic saw_stall);
        int   start_loads;
        logic got;
        start_loads       = load_count;
        fetch_req.address = addr;
        fetch_req.fetch   = 1'b1;
        @(posedge clk);
        got       = fetch_rsp.valid;
        saw_stall = fetch_rsp.stall;
        latency   = 1;
        @(negedge clk);
        fetch_req.fetch = 1'b0;
        while (!got && latency < TIMEOUT) begin
            @(posedge clk);
            got       = fetch_rsp.valid;
            saw_stall = saw_stall | fetch_rsp.stall;
            latency++;
            @(negedge clk);
        end
        if (!got) begin
            timeout_count++;
            $display("Timeout: the fetch at %08h never got a valid response", addr);
        end
        loads = load_count - start_loads;
    endtask

    task automatic fetch_and_check(input logic [31:0] addr, input int kind);
        int   latency;
        int   loads;
        logic saw_stall;
        run_fetch(addr, latency, loads, saw_stall);
        case (kind)
            KIND_SEQ: begin
                check_int("fetch_rsp_o.valid latency", latency, 1);
                check_int("load_req_o.request count", loads, 0);
                check_flag("fetch_rsp_o.stall", saw_stall, 1'b0);
            end
            KIND_HIT: begin
                check_int("fetch_rsp_o.valid latency", latency, 2);
                check_int("load_req_o.request count", loads, 0);
                check_flag("fetch_rsp_o.stall", saw_stall, 1'b0);
            end
            KIND_MISS: begin
                check_int("load_req_o.request count", loads, 1);
                check_flag("fetch_rsp_o.stall", saw_stall, 1'b1);
            end
            default: begin
                if (loads > 1) begin
                    error_count++;
                    $display("The fetch at %08h caused more than one load request", addr);
                end
            end
        endcase
    endtask

    task automatic pulse_invalidate();
        fetch_req.invalidate = 1'b1;
        @(negedge clk);
        fetch_req.invalidate = 1'b0;
    endtask

    initial begin : stimulus
        int          cycles;
        logic [31:0] pc;
        fetch_req = '0;
        void'($urandom(32'h20f4402c));

        cycles = 0;
        while (!rst_n && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!rst_n) begin
            timeout_count++;
            $display("Timeout: reset was never released");
        end
        @(negedge clk);
        check_flag("fetch_rsp_o.stall", fetch_rsp.stall, 1'b0);
        check_flag("fetch_rsp_o.valid", fetch_rsp.valid, 1'b0);
        check_flag("load_req_o.request", load_req.request, 1'b0);

        // A cold miss is followed by the rest of the block from the sequencer
        pc = 32'h0000_1008;
        fetch_and_check(pc, KIND_MISS);
        for (int i = 1; i < 6; i++) begin
            fetch_and_check(pc + 32'(4 * i), KIND_SEQ);
        end

        // Jumps back into a cached block
        fetch_and_check(pc, KIND_HIT);
        fetch_and_check(32'h0000_1000, KIND_HIT);

        // Same index with another tag evicts the first block
        fetch_and_check(pc + 32'(CACHE_SIZE), KIND_MISS);
        fetch_and_check(pc, KIND_MISS);
        fetch_and_check(pc + 32'd4, KIND_SEQ);

        // Invalidate forces a new refill
        pulse_invalidate();
        fetch_and_check(pc, KIND_MISS);
        fetch_and_check(32'h0000_1000, KIND_HIT);

        // Mostly sequential stream with random jumps in a 64 KB window
        pc = WINDOW_BASE;
        for (int n = 0; n < RANDOM_FETCHES && timeout_count == 0; n++) begin
            if ($urandom_range(99) < 32'd70) begin
                pc = pc + 32'd4;
            end else begin
                pc = WINDOW_BASE + ($urandom() & 32'h0000_fffc);
            end
            fetch_and_check(pc, KIND_ANY);
        end

        if (pending.size() != 0) begin
            error_count++;
            $display("%0d fetches never got a response", pending.size());
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d, load requests: %0d",
                 check_count, error_count, timeout_count, load_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : tb_instruction_cache_complex

// File: instruction_cache_complex.f
common/icache_pkg.sv
icache/icache_tag_array.sv
icache/icache_word_bank.sv
hw/fetch_controller.sv
hw/instruction_sequencer.sv
hw/instruction_cache_complex.sv
verif/tb_clock_gen.sv
verif/tb_memory_model.sv
verif/tb_instruction_cache_complex.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module tb_instruction_cache_complex \
    -f instruction_cache_complex.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_instruction_cache_complex)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
